// ==== Makefile ====
# Verilator build and run for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
design/div_pkg.sv
design/div_operand_prep.sv
design/div_align_shifter.sv
design/div_sub_stage.sv
design/div_ctrl.sv
design/div_result_fix.sv
design/div_top.sv
sim/div_chk.sv
sim/div_tb.sv

// ==== design/div_align_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divider align shifter
// 65-bit divisor/quotient shift register with a one-hot position flag
//####################################################################

module div_align_shifter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic                       shift_left,
    input  logic                       right_step,
    input  logic                       last_step,
    input  logic [div_pkg::data_w-1:0] b_abs,
    input  logic                       co,
    output logic [div_pkg::div_w-1:0]  divisor,
    output logic [div_pkg::data_w-1:0] quot_rev,
    output logic                       flag_lsb
);

    logic [div_pkg::sr_w-1:0]  sr;
    logic [div_pkg::div_w-1:0] flag; // one-hot, marks current divisor shift

    assign divisor  = sr[div_pkg::sr_w-1:div_pkg::data_w];
    assign quot_rev = sr[div_pkg::data_w-1:0];
    assign flag_lsb = flag[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sr   <= '0;
            flag <= '0;
        end else if (load) begin
            // divisor pre-shifted by one, quotient field cleared
            sr   <= {b_abs, 1'b0, {div_pkg::data_w{1'b0}}};
            flag <= div_pkg::flag_init;
        end else if (shift_left) begin
            sr   <= {sr[div_pkg::sr_w-2:0], 1'b0};
            flag <= {flag[div_pkg::div_w-2:0], 1'b0};
        end else if (right_step) begin
            // divisor moves down one, co lands at bit 30 as the next reversed
            // quotient bit. bit 31 catches the divisor lsb and is dropped on
            // the following step. during the align correction co is low and
            // bit 31 is still zero, so this matches a plain right shift
            sr   <= {1'b0, sr[div_pkg::sr_w-1:div_pkg::data_w], co,
                     sr[div_pkg::data_w-2:1]};
            flag <= {1'b0, flag[div_pkg::div_w-1:1]};
        end else if (last_step) begin
            sr[div_pkg::data_w-1] <= co; // quotient lsb, no shift
        end
    end

endmodule

`default_nettype wire

// ==== design/div_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divider control
// idle/align/iterate sequencing and the result valid handshake
//####################################################################

module div_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic opn_valid,
    input  logic res_ready,
    input  logic co,
    input  logic flag_lsb,
    output logic load,
    output logic shift_left,
    output logic right_step,
    output logic last_step,
    output logic res_valid,
    output logic busy
);

    // idle: !running, aligning: running & aligning, iterating: running & !aligning
    logic running;
    logic aligning;

    assign busy = running | res_valid; // pending result blocks new operands too

    // one-way operand handshake, taken whenever idle
    assign load       = opn_valid & ~busy;
    assign shift_left = running & aligning & co;
    // align overshoot correction and the regular iterate step share one command
    assign right_step = running & ((aligning & ~co) | (~aligning & ~flag_lsb));
    assign last_step  = running & ~aligning & flag_lsb;

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            aligning <= 1'b0;
        end else if (load) begin
            running  <= 1'b1;
            aligning <= 1'b1;
        end else if (running & aligning & ~co) begin
            aligning <= 1'b0; // divisor passed the remainder
        end else if (last_step) begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (last_step) begin
            res_valid <= 1'b1;
        end else if (res_valid & res_ready) begin
            res_valid <= 1'b0; // transfer done
        end
    end

endmodule

`default_nettype wire

// ==== design/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divider operand prep
// absolute values of the live operands, sign info saved on load
//####################################################################

module div_operand_prep (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic [div_pkg::data_w-1:0] a,
    input  logic [div_pkg::data_w-1:0] b,
    input  logic                       sign,
    output logic [div_pkg::data_w-1:0] a_abs,
    output logic [div_pkg::data_w-1:0] b_abs,
    output logic                       a_neg_s,
    output logic                       b_neg_s,
    output logic                       sign_s
);

    logic a_neg;
    logic b_neg;

    assign a_neg = sign & a[div_pkg::data_w-1];
    assign b_neg = sign & b[div_pkg::data_w-1];

    // only sampled in the load cycle
    assign a_abs = a_neg ? (~a + 1'b1) : a;
    assign b_abs = b_neg ? (~b + 1'b1) : b;

    // core may forward new data onto a/b mid-divide, keep our own copy
    always_ff @(posedge clk) begin
        if (rst) begin
            a_neg_s <= 1'b0;
            b_neg_s <= 1'b0;
            sign_s  <= 1'b0;
        end else if (load) begin
            a_neg_s <= a_neg;
            b_neg_s <= b_neg;
            sign_s  <= sign;
        end
    end

endmodule

`default_nettype wire

// ==== design/div_pkg.sv ====
`default_nettype none
//####################################################################
// divider package
// widths and initial flag value shared by the divide unit RTL
//####################################################################

package div_pkg;

    localparam int data_w = 32;             // operand width
    localparam int sr_w   = 2 * data_w + 1; // divisor field + reversed quotient
    localparam int div_w  = data_w + 1;     // divisor field and subtractor width
    localparam int res_w  = 2 * data_w;     // {remainder, quotient}

    // divisor is loaded pre-shifted by one, so the position marker starts at bit 1
    // one bit wider than the operands so a shift up to b<<32 keeps its marker
    localparam logic [div_w-1:0] flag_init = div_w'(2);

endpackage

`default_nettype wire

// ==== design/div_result_fix.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divider result fix
// quotient bit reversal and sign correction of quotient and remainder
//####################################################################

module div_result_fix (
    input  logic [div_pkg::data_w-1:0] quot_rev,
    input  logic [div_pkg::data_w-1:0] remainder,
    input  logic                       a_neg_s,
    input  logic                       b_neg_s,
    input  logic                       sign_s,
    output logic [div_pkg::res_w-1:0]  result
);

    logic [div_pkg::data_w-1:0] quot;
    logic [div_pkg::data_w-1:0] quot_fix;
    logic [div_pkg::data_w-1:0] rem_fix;

    for (genvar i = 0; i < div_pkg::data_w; i++) begin : g_rev
        assign quot[i] = quot_rev[div_pkg::data_w-1-i];
    end

    // truncation toward zero
    assign quot_fix = (sign_s & (a_neg_s ^ b_neg_s)) ? (~quot + 1'b1) : quot;
    // remainder follows the dividend sign
    assign rem_fix  = (sign_s & a_neg_s) ? (~remainder + 1'b1) : remainder;

    assign result = {rem_fix, quot_fix};

endmodule

`default_nettype wire

// ==== design/div_sub_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divider subtract stage
// ripple-carry remainder minus divisor, remainder register and mux
//####################################################################

module div_sub_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic                       right_step,
    input  logic                       last_step,
    input  logic [div_pkg::data_w-1:0] a_abs,
    input  logic [div_pkg::div_w-1:0]  divisor,
    output logic [div_pkg::data_w-1:0] remainder,
    output logic                       co
);

    logic [div_pkg::div_w-1:0] rem_ext;
    logic [div_pkg::div_w-1:0] div_inv;
    logic [div_pkg::div_w-1:0] diff;
    logic [div_pkg::div_w:0]   carry;

    assign rem_ext  = {1'b0, remainder};
    assign div_inv  = ~divisor;
    assign carry[0] = 1'b1; // +1 completes the two's complement

    for (genvar i = 0; i < div_pkg::div_w; i++) begin : g_fa
        assign diff[i]    = rem_ext[i] ^ div_inv[i] ^ carry[i];
        assign carry[i+1] = (rem_ext[i] & div_inv[i]) |
                            (rem_ext[i] & carry[i]) |
                            (div_inv[i] & carry[i]);
    end

    // no borrow out of 33 bits, divisor fits
    assign co = carry[div_pkg::div_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            remainder <= '0;
        end else if (load) begin
            remainder <= a_abs;
        end else if ((right_step | last_step) & co) begin
            remainder <= diff[div_pkg::data_w-1:0]; // diff fits in 32 bits here
        end
    end

endmodule

`default_nettype wire

// ==== design/div_top.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divide unit top
// self-aligning restoring divider for the HI/LO pair of the core
//####################################################################

module div_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [div_pkg::data_w-1:0] a,         // dividend
    input  logic [div_pkg::data_w-1:0] b,         // divisor
    input  logic                       sign,      // 1 for signed
    input  logic                       opn_valid,
    input  logic                       res_ready,
    output logic                       res_valid,
    output logic                       busy,
    output logic [div_pkg::res_w-1:0]  result     // {remainder, quotient}
);

    logic                       load;
    logic                       shift_left;
    logic                       right_step;
    logic                       last_step;
    logic                       co;
    logic                       flag_lsb;
    logic [div_pkg::data_w-1:0] a_abs;
    logic [div_pkg::data_w-1:0] b_abs;
    logic                       a_neg_s;
    logic                       b_neg_s;
    logic                       sign_s;
    logic [div_pkg::div_w-1:0]  divisor;
    logic [div_pkg::data_w-1:0] quot_rev;
    logic [div_pkg::data_w-1:0] remainder;

    div_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .opn_valid  (opn_valid),
        .res_ready  (res_ready),
        .co         (co),
        .flag_lsb   (flag_lsb),
        .load       (load),
        .shift_left (shift_left),
        .right_step (right_step),
        .last_step  (last_step),
        .res_valid  (res_valid),
        .busy       (busy)
    );

    div_operand_prep u_prep (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .a       (a),
        .b       (b),
        .sign    (sign),
        .a_abs   (a_abs),
        .b_abs   (b_abs),
        .a_neg_s (a_neg_s),
        .b_neg_s (b_neg_s),
        .sign_s  (sign_s)
    );

    div_align_shifter u_shifter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .shift_left (shift_left),
        .right_step (right_step),
        .last_step  (last_step),
        .b_abs      (b_abs),
        .co         (co),
        .divisor    (divisor),
        .quot_rev   (quot_rev),
        .flag_lsb   (flag_lsb)
    );

    div_sub_stage u_sub (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .right_step (right_step),
        .last_step  (last_step),
        .a_abs      (a_abs),
        .divisor    (divisor),
        .remainder  (remainder),
        .co         (co)
    );

    div_result_fix u_fix (
        .quot_rev  (quot_rev),
        .remainder (remainder),
        .a_neg_s   (a_neg_s),
        .b_neg_s   (b_neg_s),
        .sign_s    (sign_s),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== sim/div_chk.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divide unit checker
// handshake and reset assertions, bound into the divider top
//####################################################################

module div_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      res_valid,
    input logic                      res_ready,
    input logic                      busy,
    input logic                      load,
    input logic [div_pkg::res_w-1:0] result
);

    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid)
        else $error("res_valid dropped without res_ready");

    // held result must not move under back-pressure
    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> $stable(result))
        else $error("result changed while waiting for res_ready");

    // accepted operands start a division, no stale result left behind
    a_load_starts: assert property (@(posedge clk) disable iff (rst)
        load |=> busy && !res_valid)
        else $error("accepted operands did not start a division");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !res_valid && !busy)
        else $error("res_valid or busy high after reset");

endmodule

bind div_top div_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .busy      (busy),
    .load      (load),
    .result    (result)
);

`default_nettype wire

// ==== sim/div_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
//####################################################################
// divide unit testbench
// directed and random divisions checked against a reference model
//####################################################################

module div_tb;

    localparam int          half_period    = 20;
    localparam int          timeout_cycles = 30000; // ~230 ops x 80 cycles plus margin
    localparam int          max_latency    = 80;
    localparam logic [31:0] seed           = 32'h3edd;

    logic                       clk;
    logic                       rst;
    logic [div_pkg::data_w-1:0] a;
    logic [div_pkg::data_w-1:0] b;
    logic                       sign;
    logic                       opn_valid;
    logic                       res_ready;
    logic                       res_valid;
    logic                       busy;
    logic [div_pkg::res_w-1:0]  result;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] rng_state;

    div_top uut (.*);

    always #half_period clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run stopped at the cycle limit of %0d, the DUT stalled", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // quotient truncates toward zero, remainder carries the dividend sign
    function automatic logic [63:0] ref_div(input logic [31:0] x, input logic [31:0] y,
                                            input logic s);
        logic        x_neg;
        logic        y_neg;
        logic [31:0] x_mag;
        logic [31:0] y_mag;
        logic [31:0] q;
        logic [31:0] r;
        x_neg = s & x[31];
        y_neg = s & y[31];
        x_mag = x_neg ? -x : x; // -2^31 keeps its magnitude as unsigned
        y_mag = y_neg ? -y : y;
        q = x_mag / y_mag;
        r = x_mag % y_mag;
        if (x_neg ^ y_neg)
            q = -q;
        if (x_neg)
            r = -r;
        return {r, q};
    endfunction

    task automatic check_result(input logic [63:0] expected);
        checks++;
        assert (result === expected) else begin
            errors++;
            $display("** Error at %0t: result expected %h, got %h", $time, expected, result);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic issue(input logic [31:0] x, input logic [31:0] y, input logic s);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        a         = x;
        b         = y;
        sign      = s;
        opn_valid = 1'b1;
        @(posedge clk);
        #1;
        opn_valid = 1'b0;
    endtask

    task automatic take_result(input logic [63:0] expected);
        int n;
        n = 0;
        while (!res_valid && n < max_latency) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (res_valid) else begin
            errors++;
            $display("no result came back within %0d cycles of the operands", max_latency);
        end
        if (res_valid) begin
            res_ready = 1'b1;
            check_result(expected);
            @(posedge clk);
            #1;
            res_ready = 1'b0;
        end
    endtask

    task automatic run_div(input logic [31:0] x, input logic [31:0] y, input logic s,
                           input logic [63:0] expected);
        issue(x, y, s);
        take_result(expected);
    endtask

    task automatic run_ref(input logic [31:0] x, input logic [31:0] y, input logic s);
        run_div(x, y, s, ref_div(x, y, s));
    endtask

    task automatic test_unsigned();
        run_ref(32'd100, 32'd100, 1'b0);
        run_ref(32'd5, 32'd17, 1'b0);          // a < b
        run_ref(32'd0, 32'd5, 1'b0);
        run_ref(32'd12345, 32'd1, 1'b0);
        run_ref(32'hffff_ffff, 32'd1, 1'b0);   // longest alignment
        run_ref(32'hffff_ffff, 32'd7, 1'b0);
        run_ref(32'hffff_ffff, 32'h8000_0001, 1'b0);
        run_ref(32'h7fff_ffff, 32'h8000_0000, 1'b0);
    endtask

    task automatic test_signed();
        run_ref(32'd100, 32'd7, 1'b1);
        run_ref(-32'd100, 32'd7, 1'b1);
        run_ref(32'd100, -32'd7, 1'b1);
        run_ref(-32'd100, -32'd7, 1'b1);
        run_ref(-32'd7, 32'd100, 1'b1);
        run_ref(32'h8000_0000, 32'd1, 1'b1);
        run_div(32'h8000_0000, 32'hffff_ffff, 1'b1, 64'h0000_0000_8000_0000);
    endtask

    task automatic test_backpressure();
        logic [63:0] expected;
        expected = ref_div(32'd1000, 32'd3, 1'b0);
        issue(32'd1000, 32'd3, 1'b0);
        while (!res_valid) begin
            @(posedge clk);
            #1;
        end
        // operands offered while the result is held must be ignored
        for (int i = 0; i < 20; i++) begin
            a         = 32'd77 + i;
            b         = 32'd5;
            opn_valid = (i % 2 == 0);
            check_flag("res_valid", 1'b1, res_valid);
            check_flag("busy", 1'b1, busy);
            check_result(expected);
            @(posedge clk);
            #1;
        end
        opn_valid = 1'b0;
        take_result(expected);
        check_flag("busy", 1'b0, busy); // nothing was started behind the held result
        run_ref(32'd999, 32'd10, 1'b0);
    endtask

    task automatic test_random();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift(rng_state);
            x = rng_state;
            rng_state = xorshift(rng_state);
            y = rng_state;
            rng_state = xorshift(rng_state);
            r = rng_state;
            y = y >> r[4:0]; // spread divisor sizes
            if (y == 32'd0)
                y = 32'd1;
            run_ref(x, y, r[5]);
        end
    endtask

    task automatic test_reset_mid();
        issue(32'hffff_ffff, 32'd3, 1'b0);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) begin
            check_flag("res_valid", 1'b0, res_valid);
            check_flag("busy", 1'b0, busy);
            @(posedge clk);
            #1;
        end
        run_ref(32'd1000000, 32'd999, 1'b0);
        run_ref(-32'd1000000, 32'd999, 1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        a         = '0;
        b         = '0;
        sign      = 1'b0;
        opn_valid = 1'b0;
        res_ready = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        rng_state = seed;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_unsigned();
        test_signed();
        test_backpressure();
        test_random();
        test_reset_mid();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
